/* common/eccPkg.sv */
////////////////////////////////////////
// Shared widths, register map and Hsiao matrix builders
// for the ECC memory. Modules refer to items by scoped name.
////////////////////////////////////////

package eccPkg;

  // Word geometry of the protected array
  localparam int DataWidth = 32;
  localparam int ProtWidth = $clog2(DataWidth) + 2;
  localparam int TotalWidth = DataWidth + ProtWidth;
  localparam int AddrWidth = 6;

  // Request queue sizing, the depth is also the requester's initial credit count
  localparam int ReqDepth = 4;
  localparam int ReqPtrWidth = $clog2(ReqDepth);
  localparam int ReqCntWidth = $clog2(ReqDepth + 1);

  // Saturating error counters
  localparam int CntWidth = 16;

  // Configuration port geometry
  localparam int CfgAddrWidth = 3;
  localparam int CfgDataWidth = 32;

  // Register map of the configuration block
  localparam logic [CfgAddrWidth-1:0] RegInjLo = 3'd0;
  localparam logic [CfgAddrWidth-1:0] RegInjHi = 3'd1;
  localparam logic [CfgAddrWidth-1:0] RegCorrCnt = 3'd2;
  localparam logic [CfgAddrWidth-1:0] RegUncCnt = 3'd3;
  localparam logic [CfgAddrWidth-1:0] RegErrLog = 3'd4;

  // The error log keeps the address starting at this bit
  localparam int ErrLogAddrLsb = 8;

  // Upper bounds for the matrix builders, enough for 64 data bits
  localparam int MaxProtWidth = 8;
  localparam int MaxTotalWidth = 72;

  // Syndrome code of codeword bit pos
  // Check bits sit above the data and get one-hot columns
  // Data bits take distinct odd-weight columns of weight three and up,
  // enumerated by weight and then by value
  function automatic logic [MaxProtWidth-1:0] hsiaoColumn(int dataWidth, int protWidth,
                                                         int pos);
    logic [MaxProtWidth-1:0] col;
    int seen;
    col = '0;
    seen = 0;
    if (pos >= dataWidth) begin
      col[pos - dataWidth] = 1'b1;
    end else begin
      for (int w = 3; w <= protWidth; w += 2) begin
        for (int v = 1; v < (1 << protWidth); v++) begin
          if ($countones(v) == w) begin
            // Only the pos-th candidate is kept
            if (seen == pos) begin
              col = MaxProtWidth'(v);
            end
            seen++;
          end
        end
      end
    end
    return col;
  endfunction

  // Full check matrix, row i selects the codeword bits that feed check bit i
  // Entries beyond protWidth rows or the codeword width stay zero
  function automatic logic [MaxProtWidth-1:0][MaxTotalWidth-1:0] hsiaoMatrix(int dataWidth,
                                                                            int protWidth);
    logic [MaxProtWidth-1:0][MaxTotalWidth-1:0] mat;
    logic [MaxProtWidth-1:0] col;
    mat = '0;
    for (int j = 0; j < dataWidth + protWidth; j++) begin
      col = hsiaoColumn(dataWidth, protWidth, j);
      for (int i = 0; i < protWidth; i++) begin
        mat[i][j] = col[i];
      end
    end
    return mat;
  endfunction

endpackage

/* common/eccStatusIf.sv */
////////////////////////////////////////
// Decoded error events from the memory controller
// to the configuration and status register block
////////////////////////////////////////

interface eccStatusIf;

  // One-cycle pulse per decoded read with a nonzero syndrome
  logic errValid;

  // Bit 0 flags a corrected single error, bit 1 an uncorrectable double error
  logic [1:0] err;

  // Syndrome and word address of the read that raised the event
  logic [eccPkg::ProtWidth-1:0] syndrome;
  logic [eccPkg::AddrWidth-1:0] addr;

  // The controller produces events
  modport ctrl (
    output errValid,
    output err,
    output syndrome,
    output addr
  );

  // The register block only samples them
  modport regs (
    input errValid,
    input err,
    input syndrome,
    input addr
  );

endinterface

/* ecc/hsiaoEccEnc.sv */
////////////////////////////////////////
// Combinational Hsiao SEC-DED encoder
// Data goes in the low codeword bits, check bits on top
////////////////////////////////////////

module hsiaoEccEnc #(
  parameter int DataWidth = 32
) (
  input  logic [DataWidth-1:0] data,
  output logic [DataWidth+$clog2(DataWidth)+1:0] code
);

  // Check bit count follows the usual SEC-DED bound
  localparam int ChkWidth = $clog2(DataWidth) + 2;
  localparam int CodeWidth = DataWidth + ChkWidth;

  // Matrix rows come from the shared builder so encoder and decoder agree
  localparam logic [eccPkg::MaxProtWidth-1:0][eccPkg::MaxTotalWidth-1:0] Matrix =
    eccPkg::hsiaoMatrix(DataWidth, ChkWidth);

  logic [ChkWidth-1:0] check;

  // The builder has fixed upper bounds on its matrix size
  if (CodeWidth > eccPkg::MaxTotalWidth || ChkWidth > eccPkg::MaxProtWidth) begin : genSizeCheck
    $error("hsiaoEccEnc: DataWidth exceeds the matrix builder bounds");
  end

  // Each check bit is the parity of the data bits picked by its row
  // Check columns are one-hot, so only the data part of the row matters here
  for (genvar i = 0; i < ChkWidth; i++) begin : genCheck
    assign check[i] = ^(data & Matrix[i][DataWidth-1:0]);
  end

  assign code = {check, data};

endmodule

/* ecc/hsiaoEccDec.sv */
////////////////////////////////////////
// Combinational Hsiao SEC-DED decoder
// Corrects single errors, flags double errors
////////////////////////////////////////

module hsiaoEccDec #(
  parameter int DataWidth = 32
) (
  input  logic [DataWidth+$clog2(DataWidth)+1:0] code,
  output logic [DataWidth-1:0] data,
  output logic [$clog2(DataWidth)+1:0] syndrome,
  output logic [1:0] err
);

  localparam int ChkWidth = $clog2(DataWidth) + 2;
  localparam int CodeWidth = DataWidth + ChkWidth;

  // Same matrix as the encoder
  localparam logic [eccPkg::MaxProtWidth-1:0][eccPkg::MaxTotalWidth-1:0] Matrix =
    eccPkg::hsiaoMatrix(DataWidth, ChkWidth);

  logic singleErr;

  if (CodeWidth > eccPkg::MaxTotalWidth || ChkWidth > eccPkg::MaxProtWidth) begin : genSizeCheck
    $error("hsiaoEccDec: DataWidth exceeds the matrix builder bounds");
  end

  // Syndrome bit i is the parity of the whole codeword under row i
  for (genvar i = 0; i < ChkWidth; i++) begin : genSyndrome
    assign syndrome[i] = ^(code & Matrix[i][CodeWidth-1:0]);
  end

  // A data bit flips when the syndrome points at its column
  // Check-bit errors need no correction since only data leaves the decoder
  for (genvar i = 0; i < DataWidth; i++) begin : genCorrect
    localparam logic [eccPkg::MaxProtWidth-1:0] ColCode =
      eccPkg::hsiaoColumn(DataWidth, ChkWidth, i);
    assign data[i] = code[i] ^ (syndrome == ColCode[ChkWidth-1:0]);
  end

  // All columns have odd weight, so one flipped bit gives an odd syndrome
  assign singleErr = ^syndrome;

  // Two flipped bits cancel to an even, nonzero syndrome
  assign err[0] = singleErr;
  assign err[1] = !singleErr && (syndrome != '0);

  // Distinct odd-weight columns mean at most one data bit is ever flipped,
  // and only for a syndrome classified as a single error
  always_comb begin
    assert ($countones(data ^ code[DataWidth-1:0]) <= (err[0] ? 1 : 0))
      else $error("hsiaoEccDec: correction flipped data bits outside a single error");
  end

endmodule

/* logic/eccMemCtrl.sv */
////////////////////////////////////////
// Memory controller with credit-managed request queue,
// ECC-encoded word array and two-stage read pipeline
////////////////////////////////////////

module eccMemCtrl (
  input  logic clk,
  input  logic rstN,
  input  logic reqValid,
  input  logic reqWrite,
  input  logic [eccPkg::AddrWidth-1:0] reqAddr,
  input  logic [eccPkg::DataWidth-1:0] reqWdata,
  output logic reqCredit,
  output logic rspValid,
  output logic [eccPkg::DataWidth-1:0] rspRdata,
  output logic [1:0] rspErr,
  output logic [eccPkg::ProtWidth-1:0] rspSyndrome,
  input  logic [eccPkg::TotalWidth-1:0] injMask,
  eccStatusIf.ctrl status
);

  // One queued request
  typedef struct packed {
    logic write;
    logic [eccPkg::AddrWidth-1:0] addr;
    logic [eccPkg::DataWidth-1:0] wdata;
  } reqEntryT;

  reqEntryT queue [eccPkg::ReqDepth];
  reqEntryT head;
  logic [eccPkg::ReqPtrWidth-1:0] wrPtr;
  logic [eccPkg::ReqPtrWidth-1:0] rdPtr;
  logic [eccPkg::ReqCntWidth-1:0] count;
  logic pop;

  // Word array, one codeword per address
  logic [eccPkg::TotalWidth-1:0] mem [2**eccPkg::AddrWidth];
  logic [eccPkg::TotalWidth-1:0] encCode;

  // Codeword stage of the read pipeline
  logic cwValid;
  logic [eccPkg::TotalWidth-1:0] cwData;
  logic [eccPkg::AddrWidth-1:0] cwAddr;

  // Decoder outputs and the address that rides along with the response
  logic [eccPkg::DataWidth-1:0] decData;
  logic [eccPkg::ProtWidth-1:0] decSyndrome;
  logic [1:0] decErr;
  logic [eccPkg::AddrWidth-1:0] rspAddr;

  // Pop whenever anything is queued, and hand back the credit in that same cycle
  assign pop = (count != '0);
  assign head = queue[rdPtr];
  assign reqCredit = pop;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (reqValid) begin
        wrPtr <= (wrPtr == eccPkg::ReqPtrWidth'(eccPkg::ReqDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == eccPkg::ReqPtrWidth'(eccPkg::ReqDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + eccPkg::ReqCntWidth'(reqValid) - eccPkg::ReqCntWidth'(pop);
    end
  end

  // Queue storage
  always_ff @(posedge clk) begin
    if (reqValid) begin
      queue[wrPtr] <= '{write: reqWrite, addr: reqAddr, wdata: reqWdata};
    end
  end

  hsiaoEccEnc #(
    .DataWidth(eccPkg::DataWidth)
  ) uEnc (
    .data(head.wdata),
    .code(encCode)
  );

  // A popped write lands at the end of its pop cycle with the injection mask applied
  // A popped read samples the array into the codeword stage on the same edge
  always_ff @(posedge clk) begin
    if (pop && head.write) begin
      mem[head.addr] <= encCode ^ injMask;
    end
    cwData <= mem[head.addr];
    cwAddr <= head.addr;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cwValid <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      cwValid <= pop && !head.write;
      rspValid <= cwValid;
    end
  end

  hsiaoEccDec #(
    .DataWidth(eccPkg::DataWidth)
  ) uDec (
    .code(cwData),
    .data(decData),
    .syndrome(decSyndrome),
    .err(decErr)
  );

  // Response registers hold the decoded word
  always_ff @(posedge clk) begin
    if (cwValid) begin
      rspRdata <= decData;
      rspErr <= decErr;
      rspSyndrome <= decSyndrome;
      rspAddr <= cwAddr;
    end
  end

  // Error events line up with the response they belong to
  assign status.errValid = rspValid && (rspSyndrome != '0);
  assign status.err = rspErr;
  assign status.syndrome = rspSyndrome;
  assign status.addr = rspAddr;

  // A requester that respects its credits never finds the queue full
  pushNotFull: assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> (count < eccPkg::ReqDepth))
    else $error("eccMemCtrl: request pushed without a credit");

  // Credits only come back for entries that really sit between the pointers
  // Equal pointers mean an empty queue unless the count says it is full
  creditNeedsEntry: assert property (@(posedge clk) disable iff (!rstN)
    reqCredit |-> ((wrPtr != rdPtr) || (count == eccPkg::ReqDepth)))
    else $error("eccMemCtrl: credit returned from an empty queue");

endmodule

/* logic/eccCfgRegs.sv */
////////////////////////////////////////
// Configuration and status registers for the ECC memory
// Holds the injection mask, error counters and error log
////////////////////////////////////////

module eccCfgRegs (
  input  logic clk,
  input  logic rstN,
  input  logic cfgWrite,
  input  logic cfgRead,
  input  logic [eccPkg::CfgAddrWidth-1:0] cfgAddr,
  input  logic [eccPkg::CfgDataWidth-1:0] cfgWdata,
  output logic [eccPkg::CfgDataWidth-1:0] cfgRdata,
  output logic [eccPkg::TotalWidth-1:0] injMask,
  eccStatusIf.regs status
);

  logic [eccPkg::CntWidth-1:0] corrCnt;
  logic [eccPkg::CntWidth-1:0] uncCnt;
  logic [eccPkg::ProtWidth-1:0] logSyndrome;
  logic [eccPkg::AddrWidth-1:0] logAddr;
  logic [eccPkg::CfgDataWidth-1:0] rdValue;
  logic clrCorr;
  logic clrUnc;

  // Writing either counter address clears that counter
  assign clrCorr = cfgWrite && (cfgAddr == eccPkg::RegCorrCnt);
  assign clrUnc = cfgWrite && (cfgAddr == eccPkg::RegUncCnt);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      injMask <= '0;
      corrCnt <= '0;
      uncCnt <= '0;
      logSyndrome <= '0;
      logAddr <= '0;
    end else begin
      // The mask is split over two registers, check bits in the high one
      if (cfgWrite && cfgAddr == eccPkg::RegInjLo) begin
        injMask[eccPkg::DataWidth-1:0] <= cfgWdata[eccPkg::DataWidth-1:0];
      end
      if (cfgWrite && cfgAddr == eccPkg::RegInjHi) begin
        injMask[eccPkg::TotalWidth-1:eccPkg::DataWidth] <= cfgWdata[eccPkg::ProtWidth-1:0];
      end
      // A clear wins over an event in the same cycle, counters stick at all ones
      if (clrCorr) begin
        corrCnt <= '0;
      end else if (status.errValid && status.err[0] && corrCnt != '1) begin
        corrCnt <= corrCnt + 1'b1;
      end
      if (clrUnc) begin
        uncCnt <= '0;
      end else if (status.errValid && status.err[1] && uncCnt != '1) begin
        uncCnt <= uncCnt + 1'b1;
      end
      // The log always reflects the most recent event
      if (status.errValid) begin
        logSyndrome <= status.syndrome;
        logAddr <= status.addr;
      end
    end
  end

  // Read mux, unmapped addresses read as zero
  always_comb begin
    rdValue = '0;
    case (cfgAddr)
      eccPkg::RegInjLo: rdValue = eccPkg::CfgDataWidth'(injMask[eccPkg::DataWidth-1:0]);
      eccPkg::RegInjHi: begin
        rdValue = eccPkg::CfgDataWidth'(injMask[eccPkg::TotalWidth-1:eccPkg::DataWidth]);
      end
      eccPkg::RegCorrCnt: rdValue = eccPkg::CfgDataWidth'(corrCnt);
      eccPkg::RegUncCnt: rdValue = eccPkg::CfgDataWidth'(uncCnt);
      eccPkg::RegErrLog: begin
        rdValue[eccPkg::ProtWidth-1:0] = logSyndrome;
        rdValue[eccPkg::ErrLogAddrLsb +: eccPkg::AddrWidth] = logAddr;
      end
      default: rdValue = '0;
    endcase
  end

  // Read data shows up one cycle after cfgRead
  always_ff @(posedge clk) begin
    if (cfgRead) begin
      cfgRdata <= rdValue;
    end
  end

  // Counters only go down through an explicit clearing write
  corrMonotonic: assert property (@(posedge clk) disable iff (!rstN)
    !clrCorr |=> corrCnt >= $past(corrCnt))
    else $error("eccCfgRegs: correctable count decreased without a clear");

  uncMonotonic: assert property (@(posedge clk) disable iff (!rstN)
    !clrUnc |=> uncCnt >= $past(uncCnt))
    else $error("eccCfgRegs: uncorrectable count decreased without a clear");

endmodule

/* logic/eccMem.sv */
////////////////////////////////////////
// Top level of the ECC-protected memory
// Joins controller and register block on plain ports
////////////////////////////////////////

module eccMem (
  input  logic clk,
  input  logic rstN,
  // Request channel with credit return
  input  logic reqValid,
  input  logic reqWrite,
  input  logic [eccPkg::AddrWidth-1:0] reqAddr,
  input  logic [eccPkg::DataWidth-1:0] reqWdata,
  output logic reqCredit,
  // Read responses, in request order
  output logic rspValid,
  output logic [eccPkg::DataWidth-1:0] rspRdata,
  output logic [1:0] rspErr,
  output logic [eccPkg::ProtWidth-1:0] rspSyndrome,
  // Configuration and status access
  input  logic cfgWrite,
  input  logic cfgRead,
  input  logic [eccPkg::CfgAddrWidth-1:0] cfgAddr,
  input  logic [eccPkg::CfgDataWidth-1:0] cfgWdata,
  output logic [eccPkg::CfgDataWidth-1:0] cfgRdata
);

  // Mask from the register block, applied by the controller on every write
  logic [eccPkg::TotalWidth-1:0] injMask;

  // Error events flow from the controller into the counters and log
  eccStatusIf statusIf ();

  eccMemCtrl uCtrl (
    .clk(clk),
    .rstN(rstN),
    .reqValid(reqValid),
    .reqWrite(reqWrite),
    .reqAddr(reqAddr),
    .reqWdata(reqWdata),
    .reqCredit(reqCredit),
    .rspValid(rspValid),
    .rspRdata(rspRdata),
    .rspErr(rspErr),
    .rspSyndrome(rspSyndrome),
    .injMask(injMask),
    .status(statusIf.ctrl)
  );

  eccCfgRegs uRegs (
    .clk(clk),
    .rstN(rstN),
    .cfgWrite(cfgWrite),
    .cfgRead(cfgRead),
    .cfgAddr(cfgAddr),
    .cfgWdata(cfgWdata),
    .cfgRdata(cfgRdata),
    .injMask(injMask),
    .status(statusIf.regs)
  );

endmodule

/* tb/eccMemTb.sv */
////////////////////////////////////////
// Randomized testbench for the ECC memory
// Tracks credits, models stored words and checks registers
////////////////////////////////////////

module eccMemTb;

  localparam int FillOps = 64;
  localparam int RandomOps = 200;
  localparam int SingleTrials = 24;
  localparam int DoubleTrials = 16;
  // Each injection trial costs two requests and four mask writes
  localparam int TrialOps = 6;
  localparam int TotalOps = FillOps + 2 * RandomOps + (SingleTrials + DoubleTrials) * TrialOps
    + 16;
  localparam int WatchdogCycles = TotalOps * 40 + 500;
  localparam int Words = 2 ** eccPkg::AddrWidth;

  // What a read should return, data is skipped for double errors
  typedef struct packed {
    logic chkData;
    logic [eccPkg::DataWidth-1:0] data;
    logic [1:0] err;
    logic [eccPkg::ProtWidth-1:0] syn;
  } expRspT;

  logic clk;
  logic rstN;
  logic reqValid;
  logic reqWrite;
  logic [eccPkg::AddrWidth-1:0] reqAddr;
  logic [eccPkg::DataWidth-1:0] reqWdata;
  logic reqCredit;
  logic rspValid;
  logic [eccPkg::DataWidth-1:0] rspRdata;
  logic [1:0] rspErr;
  logic [eccPkg::ProtWidth-1:0] rspSyndrome;
  logic cfgWrite;
  logic cfgRead;
  logic [eccPkg::CfgAddrWidth-1:0] cfgAddr;
  logic [eccPkg::CfgDataWidth-1:0] cfgWdata;
  logic [eccPkg::CfgDataWidth-1:0] cfgRdata;

  // Reference model of every word: data, injected bit count (capped at 2) and syndrome
  logic [eccPkg::DataWidth-1:0] modelData [Words];
  int modelFlips [Words];
  logic [eccPkg::ProtWidth-1:0] modelSyn [Words];
  // Effect of the mask that is currently programmed
  int maskFlips;
  logic [eccPkg::ProtWidth-1:0] maskSyn;
  expRspT expQ [$];
  expRspT rspExp;
  int credits;
  int accepted;
  int creditPulses;
  int expCorr;
  int expUnc;
  int errors;
  int checks;
  logic [eccPkg::ProtWidth-1:0] lastSyn;
  logic [eccPkg::AddrWidth-1:0] lastAddr;
  logic [eccPkg::CfgDataWidth-1:0] rdData;

  eccMem uut (
    .clk(clk),
    .rstN(rstN),
    .reqValid(reqValid),
    .reqWrite(reqWrite),
    .reqAddr(reqAddr),
    .reqWdata(reqWdata),
    .reqCredit(reqCredit),
    .rspValid(rspValid),
    .rspRdata(rspRdata),
    .rspErr(rspErr),
    .rspSyndrome(rspSyndrome),
    .cfgWrite(cfgWrite),
    .cfgRead(cfgRead),
    .cfgAddr(cfgAddr),
    .cfgWdata(cfgWdata),
    .cfgRdata(cfgRdata)
  );

  always #10 clk = ~clk;

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Pushes one request once a credit is held, and updates the model in issue order
  task automatic issueReq(input logic write, input logic [eccPkg::AddrWidth-1:0] addr,
                          input logic [eccPkg::DataWidth-1:0] data);
    expRspT e;
    while (credits == 0) begin
      @(posedge clk);
      #1;
    end
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    reqWdata = data;
    credits--;
    accepted++;
    if (write) begin
      modelData[addr] = data;
      modelFlips[addr] = maskFlips;
      modelSyn[addr] = maskSyn;
    end else begin
      e.chkData = (modelFlips[addr] < 2);
      e.data = modelData[addr];
      // Single errors raise bit 0, double errors bit 1
      e.err = (modelFlips[addr] == 0) ? 2'b00 : (modelFlips[addr] == 1) ? 2'b01 : 2'b10;
      e.syn = modelSyn[addr];
      expQ.push_back(e);
      if (modelFlips[addr] != 0) begin
        lastSyn = modelSyn[addr];
        lastAddr = addr;
        if (modelFlips[addr] == 1) begin
          expCorr++;
        end else begin
          expUnc++;
        end
      end
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic writeReg(input logic [eccPkg::CfgAddrWidth-1:0] addr,
                          input logic [eccPkg::CfgDataWidth-1:0] data);
    cfgWrite = 1'b1;
    cfgAddr = addr;
    cfgWdata = data;
    @(posedge clk);
    #1;
    cfgWrite = 1'b0;
  endtask

  // Read data is registered, so it is taken just after the sampling edge
  task automatic readReg(input logic [eccPkg::CfgAddrWidth-1:0] addr,
                         output logic [eccPkg::CfgDataWidth-1:0] data);
    cfgRead = 1'b1;
    cfgAddr = addr;
    @(posedge clk);
    #1;
    cfgRead = 1'b0;
    data = cfgRdata;
  endtask

  // Programs the injection mask and predicts the syndrome it will cause
  task automatic setMask(input logic [eccPkg::TotalWidth-1:0] mask);
    int flips;
    logic [eccPkg::ProtWidth-1:0] syn;
    logic [eccPkg::MaxProtWidth-1:0] col;
    flips = 0;
    syn = '0;
    for (int p = 0; p < eccPkg::TotalWidth; p++) begin
      if (mask[p]) begin
        col = eccPkg::hsiaoColumn(eccPkg::DataWidth, eccPkg::ProtWidth, p);
        syn = syn ^ col[eccPkg::ProtWidth-1:0];
        flips++;
      end
    end
    writeReg(eccPkg::RegInjLo, mask[eccPkg::DataWidth-1:0]);
    writeReg(eccPkg::RegInjHi, 32'(mask[eccPkg::TotalWidth-1:eccPkg::DataWidth]));
    maskFlips = (flips > 2) ? 2 : flips;
    maskSyn = syn;
  endtask

  // Idle means every credit is back and every read has answered
  task automatic waitIdle();
    while (expQ.size() != 0 || credits != eccPkg::ReqDepth) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  // Random reads and writes back to back, with an occasional pause
  task automatic runRandom(input int n);
    logic write;
    logic [eccPkg::AddrWidth-1:0] addr;
    logic [eccPkg::DataWidth-1:0] data;
    repeat (n) begin
      write = 1'($urandom);
      addr = eccPkg::AddrWidth'($urandom);
      data = $urandom;
      if ($urandom_range(7, 0) == 0) begin
        repeat (3) @(posedge clk);
        #1;
      end
      issueReq(write, addr, data);
    end
  endtask

  // Writes one word through a mask of one or two bits, then reads it back clean
  task automatic injectTrials(input int n, input int bits);
    logic [eccPkg::TotalWidth-1:0] mask;
    logic [eccPkg::AddrWidth-1:0] addr;
    int p;
    int q;
    repeat (n) begin
      p = $urandom_range(eccPkg::TotalWidth - 1, 0);
      q = p;
      while (q == p) begin
        q = $urandom_range(eccPkg::TotalWidth - 1, 0);
      end
      mask = '0;
      mask[p] = 1'b1;
      if (bits == 2) begin
        mask[q] = 1'b1;
      end
      addr = eccPkg::AddrWidth'($urandom);
      setMask(mask);
      issueReq(1'b1, addr, $urandom);
      // The write has to leave the queue before the mask goes away
      waitIdle();
      setMask('0);
      issueReq(1'b0, addr, '0);
    end
  endtask

  // Credits and responses are taken at the falling edge, away from input changes
  always @(negedge clk) begin
    if (rstN && reqCredit) begin
      credits++;
      creditPulses++;
      if (credits > eccPkg::ReqDepth) begin
        errors++;
        $display("Credit counter rose above the queue depth at %0t", $time);
      end
    end
    if (rstN && rspValid) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("Read response arrived with no read outstanding at %0t", $time);
      end else begin
        rspExp = expQ.pop_front();
        compareValue("rspErr", 32'(rspErr), 32'(rspExp.err));
        compareValue("rspSyndrome", 32'(rspSyndrome), 32'(rspExp.syn));
        if (rspExp.chkData) begin
          compareValue("rspRdata", rspRdata, rspExp.data);
        end
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired: requests or responses stalled before the tests ended");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(6052));
    clk = 1'b0;
    rstN = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    cfgWrite = 1'b0;
    cfgRead = 1'b0;
    cfgAddr = '0;
    cfgWdata = '0;
    credits = eccPkg::ReqDepth;
    accepted = 0;
    creditPulses = 0;
    expCorr = 0;
    expUnc = 0;
    errors = 0;
    checks = 0;
    maskFlips = 0;
    maskSyn = '0;
    lastSyn = '0;
    lastAddr = '0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    // Every word gets a clean codeword first so later reads are defined
    for (int a = 0; a < Words; a++) begin
      issueReq(1'b1, eccPkg::AddrWidth'(a), $urandom);
    end
    runRandom(RandomOps);
    waitIdle();
    injectTrials(SingleTrials, 1);
    injectTrials(DoubleTrials, 2);
    // Random traffic again, now also hitting words that still hold injected errors
    runRandom(RandomOps);
    waitIdle();
    readReg(eccPkg::RegCorrCnt, rdData);
    compareValue("cfgRdata RegCorrCnt", rdData, 32'(expCorr));
    readReg(eccPkg::RegUncCnt, rdData);
    compareValue("cfgRdata RegUncCnt", rdData, 32'(expUnc));
    // Log layout has the syndrome at the bottom and the address from bit 8
    readReg(eccPkg::RegErrLog, rdData);
    compareValue("cfgRdata RegErrLog", rdData, {18'b0, lastAddr, 1'b0, lastSyn});
    writeReg(eccPkg::RegCorrCnt, '0);
    writeReg(eccPkg::RegUncCnt, '0);
    readReg(eccPkg::RegCorrCnt, rdData);
    compareValue("cfgRdata RegCorrCnt after clear", rdData, '0);
    readReg(eccPkg::RegUncCnt, rdData);
    compareValue("cfgRdata RegUncCnt after clear", rdData, '0);
    compareValue("reqCredit pulse count", 32'(creditPulses), 32'(accepted));
    compareValue("held credits", 32'(credits), 32'(eccPkg::ReqDepth));
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* eccMem.f */
common/eccPkg.sv
common/eccStatusIf.sv
ecc/hsiaoEccEnc.sv
ecc/hsiaoEccDec.sv
logic/eccMemCtrl.sv
logic/eccCfgRegs.sv
logic/eccMem.sv
tb/eccMemTb.sv

/* run.sh */
#!/bin/sh
# Builds the ECC memory testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f eccMem.f --top-module eccMemTb -o eccMemSim
simOut=$(./obj_dir/eccMemSim)
echo "$simOut"
if echo "$simOut" | grep -q "RESULT: PASS"; then
  exit 0
fi
exit 1
